// ==== sources.f ====
+incdir+hw
hw/icache_pkg.sv
hw/wb_pkg.sv
hw/fetch_pc_stage.sv
hw/icache_lookup.sv
hw/wb_fetch_master.sv
hw/fetch_out_stage.sv
hw/fetch_top.sv
verif/wb_mem_model.sv
verif/tb_fetch_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_fetch_top -o sim_tb_fetch_top

out=$(./obj_dir/sim_tb_fetch_top)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// ==== verif/tb_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top
    import icache_pkg::*;
();

    // about 80 line refills of at most ~60 cycles, plus stalls and idle gaps
    localparam int TIMEOUT = 80 * 64 + 2000;

    logic        clk;
    logic        reset;
    logic        redirect_i;
    logic [31:0] redirect_pc_i;
    logic        ready_i;
    logic        fetch_valid_o;
    logic [31:0] fetch_pc_o;
    logic [31:0] fetch_inst0_o;
    logic [31:0] fetch_inst1_o;
    logic [1:0]  fetch_slot_valid_o;
    logic        fetch_fault_o;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic [31:0] ack_count;

    logic [31:0] exp_pc;
    logic        fault_hold;
    logic        random_ready;
    logic [31:0] ack_log [$];
    int          errors;
    int          checks;
    int          pairs;
    int          cycle_count;

    fetch_top dut (
        .clk(clk), .reset(reset), .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
        .ready_i(ready_i), .fetch_valid_o(fetch_valid_o), .fetch_pc_o(fetch_pc_o),
        .fetch_inst0_o(fetch_inst0_o), .fetch_inst1_o(fetch_inst1_o),
        .fetch_slot_valid_o(fetch_slot_valid_o), .fetch_fault_o(fetch_fault_o),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_i(wb_dat), .wb_ack_i(wb_ack)
    );

    wb_mem_model mem (
        .clk(clk), .reset(reset), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_o(wb_dat), .wb_ack_o(wb_ack), .ack_count_o(ack_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        lookup_state_e st;
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            st = lookup_state_e'(dut.u_lookup.state_q);
            $display("timeout after %0d cycles, lookup state %s", cycle_count, st.name());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return mem.words[addr[11:2]];
    endfunction

    function automatic int acks_in(input logic [31:0] lo, input logic [31:0] hi, input int from);
        int n;
        n = 0;
        for (int i = from; i < ack_log.size(); i++) begin
            if (ack_log[i] >= lo && ack_log[i] < hi) n++;
        end
        return n;
    endfunction

    task automatic check_pair();
        logic [31:0] base;
        base = exp_pc & ~32'h7;
        if (fault_hold) begin
            $display("%0t pair delivered while waiting for a redirect after a fault", $time);
            errors = errors + 1;
        end
        compare("fetch_pc_o", fetch_pc_o, exp_pc);
        if (exp_pc[1:0] != 2'b00) begin
            compare("fetch_fault_o", 32'(fetch_fault_o), 32'd1);
            compare("fetch_slot_valid_o", 32'(fetch_slot_valid_o), 32'd0);
            fault_hold = 1'b1;
        end else begin
            compare("fetch_fault_o", 32'(fetch_fault_o), 32'd0);
            compare("fetch_slot_valid_o", 32'(fetch_slot_valid_o), {30'd0, 1'b1, !exp_pc[2]});
            if (!exp_pc[2]) compare("fetch_inst0_o", fetch_inst0_o, mem_word(base));
            compare("fetch_inst1_o", fetch_inst1_o, mem_word(base + 32'd4));
        end
        exp_pc = (exp_pc & ~32'h4) + 32'd8;
        pairs = pairs + 1;
    endtask

    // sample at the edge, then drive the next inputs 1 ns later
    task automatic step();
        @(posedge clk);
        if (wb_cyc && wb_stb && wb_ack) begin
            ack_log.push_back(wb_adr);
            compare("wb_we_o", 32'(wb_we), 32'd0);
        end
        if (fetch_valid_o && ready_i) check_pair();
        if (redirect_i) begin
            exp_pc     = redirect_pc_i;
            fault_hold = 1'b0;
        end
        #1;
        redirect_i = 1'b0;
        ready_i    = random_ready ? 1'($urandom % 2) : 1'b1;
    endtask

    task automatic redirect_to(input logic [31:0] target);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        step();
    endtask

    task automatic get_pairs(input int n);
        int target;
        target = pairs + n;
        while (pairs < target) step();
    endtask

    task automatic expect_acks(input string what, input int got, input int exp);
        compare({what, " bus reads"}, 32'(got), 32'(exp));
    endtask

    task automatic end_test(input string name, input int err_before);
        $display("test %s: %s (%0d errors)", name,
                 (errors == err_before) ? "ok" : "failed", errors - err_before);
    endtask

    initial begin
        int e0;
        int mark;
        logic [31:0] a_line;
        logic [31:0] b_line;
        logic [31:0] c_line;
        logic [31:0] u;
        reset         = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = 32'd0;
        ready_i       = 1'b1;
        random_ready  = 1'b0;
        exp_pc        = 32'd0;
        fault_hold    = 1'b0;
        errors        = 0;
        checks        = 0;
        pairs         = 0;
        cycle_count   = 0;
        void'($urandom(32'h4491));
        for (int i = 0; i < 1024; i++) mem.words[i] = $urandom;
        repeat (3) step();
        reset = 1'b0;

        e0 = errors;
        compare("fetch_valid_o", 32'(fetch_valid_o), 32'd0);
        compare("wb_cyc_o", 32'(wb_cyc), 32'd0);
        compare("wb_stb_o", 32'(wb_stb), 32'd0);
        get_pairs(32);
        end_test("cold_sequential", e0);

        e0 = errors;
        mark = ack_log.size();
        redirect_to(32'h0000_0400);
        get_pairs(8);
        expect_acks("loop first pass", acks_in(32'h400, 32'h440, mark), 16);
        mark = ack_log.size();
        redirect_to(32'h0000_0400);
        get_pairs(8);
        expect_acks("loop refetch", acks_in(32'h400, 32'h440, mark), 0);
        a_line = 32'h0001_0200;  // one set, three tags
        b_line = 32'h0002_0200;
        c_line = 32'h0003_0200;
        mark = ack_log.size();
        redirect_to(a_line);
        get_pairs(1);
        redirect_to(b_line);
        get_pairs(1);
        redirect_to(a_line);
        get_pairs(1);
        redirect_to(c_line);
        get_pairs(1);
        expect_acks("line A", acks_in(a_line, a_line + 32, mark), 8);
        expect_acks("line B", acks_in(b_line, b_line + 32, mark), 8);
        expect_acks("line C", acks_in(c_line, c_line + 32, mark), 8);
        mark = ack_log.size();
        redirect_to(a_line);
        get_pairs(1);
        expect_acks("line A after C", acks_in(a_line, a_line + 32, mark), 0);
        end_test("warm_hits_lru", e0);

        e0 = errors;
        for (int r = 0; r < 20; r++) begin
            redirect_to(($urandom % 32'h4000) & ~32'h3);
            get_pairs(1 + int'($urandom % 3));
        end
        end_test("random_redirects", e0);

        e0 = errors;
        u = 32'h8000_0100;
        for (int r = 0; r < 2; r++) begin
            mark = ack_log.size();
            redirect_to(u);
            get_pairs(4);
            expect_acks("uncached pass", acks_in(u, u + 32, mark), 8);
        end
        mark = ack_log.size();
        redirect_to(u + 32'd4);
        get_pairs(1);
        expect_acks("uncached odd slot", acks_in(u, u + 8, mark), 1);
        end_test("uncached", e0);

        e0 = errors;
        random_ready = 1'b1;
        redirect_to(32'h0000_0600);
        get_pairs(40);
        random_ready = 1'b0;
        end_test("back_pressure", e0);

        e0 = errors;
        redirect_to(32'h0000_0702);
        get_pairs(1);
        repeat (40) step();
        redirect_to(32'h0000_0800);
        get_pairs(2);
        while (wb_ack) step();  // last ack not yet logged
        compare("ack_count_o", ack_count, 32'(ack_log.size()));
        end_test("misaligned_fault", e0);

        $display("tests 6, pairs %0d, checks %0d, errors %0d", pairs, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/wb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic [31:0] ack_count_o
);

    localparam int WORDS = 1024;  // 4 KB, aliased

    logic [31:0] words [WORDS];
    logic        busy_q;
    logic [1:0]  wait_q;
    logic        rd_req;

    // read-only slave, writes are never acked as stores
    assign rd_req = wb_cyc_i && wb_stb_i && !wb_we_i && !wb_ack_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack_o    <= 1'b0;
            busy_q      <= 1'b0;
            wait_q      <= 2'd0;
            ack_count_o <= 32'd0;
        end else begin
            wb_ack_o <= 1'b0;
            if (rd_req) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= 2'($urandom % 4);  // 0 to 3 wait states
                end else if (wait_q == 2'd0) begin
                    wb_ack_o    <= 1'b1;
                    wb_dat_o    <= words[wb_adr_i[11:2]];
                    busy_q      <= 1'b0;
                    ack_count_o <= ack_count_o + 32'd1;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        ready_i,
    output logic        fetch_valid_o,
    output logic [31:0] fetch_pc_o,
    output logic [31:0] fetch_inst0_o,
    output logic [31:0] fetch_inst1_o,
    output logic [1:0]  fetch_slot_valid_o,
    output logic        fetch_fault_o,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output logic [31:0] wb_adr_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i
);

    logic [31:0] pc;
    logic        pc_valid;
    logic        advance;
    logic        out_ready;
    logic        pair_valid;
    logic [31:0] pair_pc;
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic [1:0]  slot_valid;
    logic        fault;
    logic        req;
    wb_req_e     req_kind;
    logic [31:0] req_addr;
    logic        beat_valid;
    beat_t       beat_idx;
    logic [31:0] beat_data;
    logic        done;

    fetch_pc_stage u_pc (
        .clk(clk), .reset(reset), .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
        .advance_i(advance), .pc_o(pc), .pc_valid_o(pc_valid)
    );

    icache_lookup u_lookup (
        .clk(clk), .reset(reset), .redirect_i(redirect_i),
        .pc_i(pc), .pc_valid_i(pc_valid), .advance_o(advance), .out_ready_i(out_ready),
        .pair_valid_o(pair_valid), .pair_pc_o(pair_pc), .inst0_o(inst0), .inst1_o(inst1),
        .slot_valid_o(slot_valid), .fault_o(fault),
        .req_o(req), .req_kind_o(req_kind), .req_addr_o(req_addr),
        .beat_valid_i(beat_valid), .beat_idx_i(beat_idx), .beat_data_i(beat_data),
        .done_i(done)
    );

    wb_fetch_master u_wb (
        .clk(clk), .reset(reset),
        .req_i(req), .req_kind_i(req_kind), .req_addr_i(req_addr),
        .beat_valid_o(beat_valid), .beat_idx_o(beat_idx), .beat_data_o(beat_data),
        .done_o(done), .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
        .wb_adr_o(wb_adr_o), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
    );

    fetch_out_stage u_out (
        .clk(clk), .reset(reset), .redirect_i(redirect_i),
        .pair_valid_i(pair_valid), .pair_pc_i(pair_pc), .inst0_i(inst0), .inst1_i(inst1),
        .slot_valid_i(slot_valid), .fault_i(fault), .out_ready_o(out_ready),
        .ready_i(ready_i), .fetch_valid_o(fetch_valid_o), .fetch_pc_o(fetch_pc_o),
        .fetch_inst0_o(fetch_inst0_o), .fetch_inst1_o(fetch_inst1_o),
        .fetch_slot_valid_o(fetch_slot_valid_o), .fetch_fault_o(fetch_fault_o)
    );

endmodule

`default_nettype wire

// ==== hw/fetch_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_out_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect_i,
    input  logic        pair_valid_i,
    input  logic [31:0] pair_pc_i,
    input  logic [31:0] inst0_i,
    input  logic [31:0] inst1_i,
    input  logic [1:0]  slot_valid_i,
    input  logic        fault_i,
    output logic        out_ready_o,
    input  logic        ready_i,
    output logic        fetch_valid_o,
    output logic [31:0] fetch_pc_o,
    output logic [31:0] fetch_inst0_o,
    output logic [31:0] fetch_inst1_o,
    output logic [1:0]  fetch_slot_valid_o,
    output logic        fetch_fault_o
);

    assign out_ready_o = !fetch_valid_o || ready_i;  // empty or draining

    always_ff @(posedge clk) begin
        if (reset || redirect_i) begin
            fetch_valid_o <= 1'b0;
        end else if (out_ready_o) begin
            fetch_valid_o <= pair_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (out_ready_o && pair_valid_i) begin
            fetch_pc_o         <= pair_pc_i;
            fetch_inst0_o      <= inst0_i;
            fetch_inst1_o      <= inst1_i;
            fetch_slot_valid_o <= slot_valid_i;
            fetch_fault_o      <= fault_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/wb_fetch_master.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module wb_fetch_master
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_i,
    input  wb_req_e     req_kind_i,
    input  logic [31:0] req_addr_i,
    output logic        beat_valid_o,
    output beat_t       beat_idx_o,
    output logic [31:0] beat_data_o,
    output logic        done_o,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output logic [31:0] wb_adr_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUS  = 2'd1;
    localparam logic [1:0] ST_GAP  = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;
    localparam int OFFSET_BITS = `ICACHE_WORD_BITS + 2;

    logic [1:0] state_q;
    beat_t      beat_q;
    logic       last_beat;

    assign last_beat = (req_kind_i == REQ_WORD) ||
                       (beat_q == beat_t'(`ICACHE_LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q <= ST_BUS;
                        beat_q  <= '0;
                    end
                end
                ST_BUS: begin
                    if (wb_ack_i) begin
                        state_q <= last_beat ? ST_DONE : ST_GAP;
                        if (!last_beat) beat_q <= beat_q + beat_t'(1);
                    end
                end
                ST_GAP:  state_q <= ST_BUS;   // stb low for one cycle
                default: state_q <= ST_IDLE;  // done pulse
            endcase
        end
    end

    assign wb_cyc_o = (state_q == ST_BUS);
    assign wb_stb_o = (state_q == ST_BUS);
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = (req_kind_i == REQ_WORD) ? {req_addr_i[31:2], 2'b00} :
                      {req_addr_i[31:OFFSET_BITS], beat_q, 2'b00};

    assign beat_valid_o = (state_q == ST_BUS) && wb_ack_i;
    assign beat_idx_o   = (req_kind_i == REQ_WORD) ? beat_t'(0) : beat_q;
    assign beat_data_o  = wb_dat_i;
    assign done_o       = (state_q == ST_DONE);  // one cycle after the last beat

endmodule

`default_nettype wire

// ==== hw/icache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_lookup
    import icache_pkg::*;
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect_i,
    input  logic [31:0] pc_i,
    input  logic        pc_valid_i,
    output logic        advance_o,
    input  logic        out_ready_i,
    output logic        pair_valid_o,
    output logic [31:0] pair_pc_o,
    output logic [31:0] inst0_o,
    output logic [31:0] inst1_o,
    output logic [1:0]  slot_valid_o,
    output logic        fault_o,
    output logic        req_o,
    output wb_req_e     req_kind_o,
    output logic [31:0] req_addr_o,
    input  logic        beat_valid_i,
    input  beat_t       beat_idx_i,
    input  logic [31:0] beat_data_i,
    input  logic        done_i
);

    localparam int PAIR_BITS   = `ICACHE_WORD_BITS - 1;
    localparam int BANK_DEPTH  = `ICACHE_SETS * `ICACHE_LINE_WORDS / 2;
    localparam int OFFSET_BITS = `ICACHE_WORD_BITS + 2;

    lookup_state_e state_q;
    fetch_addr_u   pc_u;
    fetch_addr_u   req_q;
    logic          req_valid_q;
    logic          unc_have_q;
    logic          victim_q;
    logic [31:0]   unc0_q;
    logic [31:0]   unc1_q;

    // even and odd words of a line sit in separate banks, one pair per read
    logic [`ICACHE_TAG_BITS-1:0]   tag_mem  [2][`ICACHE_SETS];
    logic [31:0]                   even_mem [2][BANK_DEPTH];
    logic [31:0]                   odd_mem  [2][BANK_DEPTH];
    logic [1:0][`ICACHE_SETS-1:0]  valid_q;
    logic [`ICACHE_SETS-1:0]       lru_q;   // way to replace next

    logic [`ICACHE_TAG_BITS-1:0]   tag_rd  [2];
    logic [31:0]                   even_rd [2];
    logic [31:0]                   odd_rd  [2];
    logic [1:0]                    valid_rd;

    logic [`ICACHE_INDEX_BITS-1:0] rd_index;
    logic [PAIR_BITS-1:0]          rd_pair;
    logic [PAIR_BITS-1:0]          wr_pair;
    logic [1:0]                    hit_way;
    logic                          hit;
    logic                          live;
    logic                          fault_now;
    logic                          uncached;
    logic                          consume;
    logic                          refill_we;

    assign pc_u      = pc_i;
    assign live      = req_valid_q && !redirect_i;
    assign fault_now = req_q.f.byte_off != 2'b00;
    assign uncached  = req_q.raw[`ICACHE_UNCACHED_BIT];
    assign hit_way[0] = valid_rd[0] && (tag_rd[0] == req_q.f.tag);
    assign hit_way[1] = valid_rd[1] && (tag_rd[1] == req_q.f.tag);
    assign hit       = |hit_way;

    always_comb begin
        pair_valid_o = 1'b0;
        if (state_q == LOOKUP && req_valid_q) begin
            pair_valid_o = fault_now || (!uncached && hit);
        end else if (state_q == UNCACHED_B && req_valid_q) begin
            pair_valid_o = unc_have_q;
        end
    end

    assign consume   = pair_valid_o && out_ready_i;
    assign advance_o = pc_valid_i && !redirect_i &&
                       ((state_q == LOOKUP && !req_valid_q) || (consume && !fault_now));

    assign pair_pc_o    = req_q.raw;
    assign fault_o      = fault_now;
    assign slot_valid_o = fault_now ? 2'b00 : {1'b1, !req_q.f.word[0]};
    assign inst0_o = (state_q == UNCACHED_B) ? unc0_q : (hit_way[1] ? even_rd[1] : even_rd[0]);
    assign inst1_o = (state_q == UNCACHED_B) ? unc1_q : (hit_way[1] ? odd_rd[1] : odd_rd[0]);

    // next pc when accepting, else re-read the held set
    assign rd_index = advance_o ? pc_u.f.index : req_q.f.index;
    assign rd_pair  = advance_o ? pc_u.f.word[PAIR_BITS:1] : req_q.f.word[PAIR_BITS:1];
    assign wr_pair  = beat_idx_i[PAIR_BITS:1];

    assign refill_we  = (state_q == REFILL) && beat_valid_i;
    assign req_o      = (state_q == REFILL) || (state_q == UNCACHED_A) ||
                        (state_q == UNCACHED_B && !unc_have_q);
    assign req_kind_o = (state_q == REFILL) ? REQ_LINE : REQ_WORD;

    always_comb begin
        req_addr_o = {req_q.raw[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        if (state_q == UNCACHED_A) begin
            req_addr_o = {req_q.raw[31:3], 3'b000};
        end else if (state_q == UNCACHED_B) begin
            req_addr_o = {req_q.raw[31:3], 3'b100};
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (refill_we && int'(victim_q) == w) begin
                tag_mem[w][req_q.f.index] <= req_q.f.tag;
                if (beat_idx_i[0]) begin
                    odd_mem[w][{req_q.f.index, wr_pair}] <= beat_data_i;
                end else begin
                    even_mem[w][{req_q.f.index, wr_pair}] <= beat_data_i;
                end
            end
            tag_rd[w]   <= tag_mem[w][rd_index];
            even_rd[w]  <= even_mem[w][{rd_index, rd_pair}];
            odd_rd[w]   <= odd_mem[w][{rd_index, rd_pair}];
            valid_rd[w] <= valid_q[w][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) req_q <= pc_u;
        if (beat_valid_i && state_q == UNCACHED_A) unc0_q <= beat_data_i;
        if (beat_valid_i && state_q == UNCACHED_B) unc1_q <= beat_data_i;
        if (state_q == LOOKUP && live && !fault_now && !uncached && !hit) begin
            victim_q <= lru_q[req_q.f.index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= LOOKUP;
            req_valid_q <= 1'b0;
            unc_have_q  <= 1'b0;
            valid_q     <= '0;
            lru_q       <= '0;
        end else begin
            if (redirect_i) begin
                req_valid_q <= 1'b0;
            end else if (advance_o) begin
                req_valid_q <= 1'b1;
            end else if (consume) begin
                req_valid_q <= 1'b0;
            end
            if (refill_we) valid_q[victim_q][req_q.f.index] <= 1'b1;
            if (consume && state_q == LOOKUP && !fault_now) begin
                lru_q[req_q.f.index] <= hit_way[0];  // point at the other way
            end
            case (state_q)
                LOOKUP: begin
                    if (live && fault_now) begin
                        if (out_ready_i) state_q <= HOLD_FAULT;
                    end else if (live && uncached) begin
                        state_q    <= req_q.f.word[0] ? UNCACHED_B : UNCACHED_A;
                        unc_have_q <= 1'b0;
                    end else if (live && !hit) begin
                        state_q <= REFILL;
                    end
                end
                REFILL: begin
                    if (done_i) begin
                        state_q              <= LOOKUP;  // re-read, then hit
                        lru_q[req_q.f.index] <= !victim_q;
                    end
                end
                UNCACHED_A: begin
                    if (done_i) state_q <= live ? UNCACHED_B : LOOKUP;
                end
                UNCACHED_B: begin
                    if (!unc_have_q) begin
                        if (done_i && live) begin
                            unc_have_q <= 1'b1;
                        end else if (done_i) begin
                            state_q <= LOOKUP;
                        end
                    end else if (!live || out_ready_i) begin
                        state_q    <= LOOKUP;
                        unc_have_q <= 1'b0;
                    end
                end
                HOLD_FAULT: begin
                    if (redirect_i) state_q <= LOOKUP;
                end
                default: state_q <= LOOKUP;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch_pc_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module fetch_pc_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        advance_i,
    output logic [31:0] pc_o,
    output logic        pc_valid_o
);

    logic [31:0] pc_q;
    logic        pc_valid_q;
    logic [31:0] next_pc;

    // drop bit 2 so a mid-pair pc lands on the next pair
    assign next_pc = {pc_q[31:3], 1'b0, pc_q[1:0]} + 32'd8;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q       <= `ICACHE_RESET_PC;
            pc_valid_q <= 1'b0;
        end else begin
            pc_valid_q <= 1'b1;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;  // advance ignored this cycle
            end else if (advance_i) begin
                pc_q <= next_pc;
            end
        end
    end

    assign pc_o       = pc_q;
    assign pc_valid_o = pc_valid_q;

endmodule

`default_nettype wire

// ==== hw/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // line refill is eight beats, word fetch is one
    typedef enum logic {
        REQ_LINE = 1'b0,
        REQ_WORD = 1'b1
    } wb_req_e;

    typedef logic [2:0] beat_t;

endpackage

`default_nettype wire

// ==== hw/icache_pkg.sv ====
`default_nettype none
`include "icache_config.svh"

package icache_pkg;

    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        logic [`ICACHE_INDEX_BITS-1:0] index;
        logic [`ICACHE_WORD_BITS-1:0]  word;
        logic [1:0]                    byte_off;
    } fetch_fields_t;

    // same word, raw or split into cache fields
    typedef union packed {
        logic [31:0]   raw;
        fetch_fields_t f;
    } fetch_addr_u;

    typedef enum logic [4:0] {
        LOOKUP     = 5'b00001,
        REFILL     = 5'b00010,
        UNCACHED_A = 5'b00100,
        UNCACHED_B = 5'b01000,
        HOLD_FAULT = 5'b10000
    } lookup_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// fetch address split: tag | index | word | byte
`define ICACHE_TAG_BITS 20
`define ICACHE_INDEX_BITS 7
`define ICACHE_WORD_BITS 3

// array geometry, two ways
`define ICACHE_SETS 128
`define ICACHE_LINE_WORDS 8

// bit 31 set means uncached space
`define ICACHE_UNCACHED_BIT 31

`define ICACHE_RESET_PC 32'h0000_0000

`endif
